/* files.f */
+incdir+verilog
verilog/mips_pkg.sv
verilog/mips_if.sv
verilog/mips_decode.sv
verilog/mips_execute.sv
verilog/mips_result.sv
verilog/mips_top.sv
tests/mips_tb.sv

/* run.sh */
#!/bin/sh
# Builds and runs the mips_tb simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module mips_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vmips_tb 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q '^Finished with no errors$'; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

/* tests/mips_tb.sv */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mips_tb import mips_pkg::*; ();

    localparam int    ROM_WORDS = 256;
    localparam int    NUM_INSTR = 256;
    localparam word_t LAST_PC   = `MIPS_RESET_PC + 4 * (NUM_INSTR - 1);

    logic                   clk;
    logic                   reset_i;
    logic                   inst_sram_en_o;
    word_t                  inst_sram_addr_o;
    word_t                  inst_sram_rdata_i;
    word_t                  debug_wb_pc_o;
    logic [`MIPS_WEN_W-1:0] debug_wb_rf_wen_o;
    reg_addr_t              debug_wb_rf_wnum_o;
    word_t                  debug_wb_rf_wdata_o;

    integer  seed;
    word_t   rom [0:ROM_WORDS-1];
    word_t   model_regs [0:31];
    wb_req_t exp_q [$];
    word_t   next_pc;
    word_t   fetch_word;
    logic    fetch_started;
    logic    trace_done;
    logic    hist_vld [0:3];
    word_t   hist_pc [0:3];
    int      cycles;

    mips_top i_mips_top (
        .clk                 (clk),
        .reset_i             (reset_i),
        .inst_sram_en_o      (inst_sram_en_o),
        .inst_sram_addr_o    (inst_sram_addr_o),
        .inst_sram_rdata_i   (inst_sram_rdata_i),
        .debug_wb_pc_o       (debug_wb_pc_o),
        .debug_wb_rf_wen_o   (debug_wb_rf_wen_o),
        .debug_wb_rf_wnum_o  (debug_wb_rf_wnum_o),
        .debug_wb_rf_wdata_o (debug_wb_rf_wdata_o)
    );

    always #50 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Error exit and compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_word(input word_t actual, input word_t expected, input string what);
        if (actual !== expected)
            abort_run($sformatf("mismatch at %0t ns: %s is %h, expected %h",
                                $time, what, actual, expected));
    endtask

    task automatic check_reg(input reg_addr_t actual, input reg_addr_t expected,
                             input string what);
        if (actual !== expected)
            abort_run($sformatf("mismatch at %0t ns: %s is %0d, expected %0d",
                                $time, what, actual, expected));
    endtask

    task automatic check_wen(input logic [`MIPS_WEN_W-1:0] actual,
                             input logic [`MIPS_WEN_W-1:0] expected, input string what);
        if (actual !== expected)
            abort_run($sformatf("mismatch at %0t ns: %s is %b, expected %b",
                                $time, what, actual, expected));
    endtask

    //////////////////////////////////////////////////////////////////////
    // Random program
    //////////////////////////////////////////////////////////////////////

    function automatic word_t enc_r(input logic [5:0] funct, input reg_addr_t rs,
                                    input reg_addr_t rt, input reg_addr_t rd,
                                    input logic [4:0] sa);
        return {`MIPS_OP_SPECIAL, rs, rt, rd, sa, funct};
    endfunction

    function automatic word_t enc_i(input logic [5:0] op, input reg_addr_t rs,
                                    input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Mostly $0..$5 so that dependencies sit close together
    function automatic reg_addr_t pick_reg();
        int r;
        r = {$random(seed)} % 8;
        return (r < 6) ? reg_addr_t'(r) : reg_addr_t'($random(seed));
    endfunction

    function automatic word_t gen_instr();
        int          kind;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        logic [15:0] imm;
        logic [4:0]  sa;
        word_t       w;
        kind = {$random(seed)} % 18;
        rs   = pick_reg();
        rt   = pick_reg();
        rd   = pick_reg();
        imm  = 16'($random(seed));
        sa   = 5'($random(seed));
        case (kind)
            0:  w = enc_r(`MIPS_FN_ADDU, rs, rt, rd, 5'd0);
            1:  w = enc_r(`MIPS_FN_SUBU, rs, rt, rd, 5'd0);
            2:  w = enc_r(`MIPS_FN_AND, rs, rt, rd, 5'd0);
            3:  w = enc_r(`MIPS_FN_OR, rs, rt, rd, 5'd0);
            4:  w = enc_r(`MIPS_FN_XOR, rs, rt, rd, 5'd0);
            5:  w = enc_r(`MIPS_FN_NOR, rs, rt, rd, 5'd0);
            6:  w = enc_r(`MIPS_FN_SLT, rs, rt, rd, 5'd0);
            7:  w = enc_r(`MIPS_FN_SLTU, rs, rt, rd, 5'd0);
            8:  w = enc_r(`MIPS_FN_SLL, 5'd0, rt, rd, sa);
            9:  w = enc_r(`MIPS_FN_SRL, 5'd0, rt, rd, sa);
            10: w = enc_r(`MIPS_FN_SRA, 5'd0, rt, rd, sa);
            11: w = enc_i(`MIPS_OP_ADDIU, rs, rt, imm);
            12: w = enc_i(`MIPS_OP_ANDI, rs, rt, imm);
            13: w = enc_i(`MIPS_OP_ORI, rs, rt, imm);
            14: w = enc_i(`MIPS_OP_XORI, rs, rt, imm);
            15: w = enc_i(`MIPS_OP_LUI, 5'd0, rt, imm);
            // mult, not part of this core
            16: w = enc_r(6'h18, rs, rt, rd, 5'd0);
            // lw, not part of this core
            default: w = enc_i(6'h23, rs, rt, imm);
        endcase
        return w;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference model, one instruction at a time in program order
    //////////////////////////////////////////////////////////////////////

    task automatic run_model();
        word_t     inst;
        word_t     a;
        word_t     b;
        word_t     y;
        word_t     simm;
        word_t     zimm;
        reg_addr_t dest;
        logic      writes;
        wb_req_t   w;
        for (int r = 0; r < 32; r++)
            model_regs[r] = '0;
        for (int i = 0; i < NUM_INSTR; i++) begin
            inst   = rom[i];
            a      = model_regs[inst[25:21]];
            b      = model_regs[inst[20:16]];
            simm   = {{16{inst[15]}}, inst[15:0]};
            zimm   = {16'h0000, inst[15:0]};
            writes = 1'b1;
            dest   = inst[20:16];
            y      = '0;
            case (inst[31:26])
                `MIPS_OP_SPECIAL: begin
                    dest = inst[15:11];
                    case (inst[5:0])
                        `MIPS_FN_ADDU: y = a + b;
                        `MIPS_FN_SUBU: y = a - b;
                        `MIPS_FN_AND:  y = a & b;
                        `MIPS_FN_OR:   y = a | b;
                        `MIPS_FN_XOR:  y = a ^ b;
                        `MIPS_FN_NOR:  y = ~(a | b);
                        `MIPS_FN_SLT:  y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        `MIPS_FN_SLTU: y = (a < b) ? 32'd1 : 32'd0;
                        `MIPS_FN_SLL:  y = b << inst[10:6];
                        `MIPS_FN_SRL:  y = b >> inst[10:6];
                        `MIPS_FN_SRA:  y = word_t'($signed(b) >>> inst[10:6]);
                        default:       writes = 1'b0;
                    endcase
                end
                `MIPS_OP_ADDIU: y = a + simm;
                `MIPS_OP_ANDI:  y = a & zimm;
                `MIPS_OP_ORI:   y = a | zimm;
                `MIPS_OP_XORI:  y = a ^ zimm;
                `MIPS_OP_LUI:   y = {inst[15:0], 16'h0000};
                default:        writes = 1'b0;
            endcase
            if (writes && dest != '0) begin
                model_regs[dest] = y;
                w.pc   = `MIPS_RESET_PC + word_t'(4 * i);
                w.dest = dest;
                w.wen  = 1'b1;
                w.data = y;
                exp_q.push_back(w);
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Per-cycle ROM, fetch check and trace check
    //////////////////////////////////////////////////////////////////////

    // The instruction in the trace now was issued three cycles ago
    task automatic check_trace();
        wb_req_t w;
        if (hist_vld[3] && exp_q.size() > 0 && exp_q[0].pc == hist_pc[3]) begin
            w = exp_q.pop_front();
            check_wen(debug_wb_rf_wen_o, {`MIPS_WEN_W{1'b1}},
                      $sformatf("write enable for pc %h", w.pc));
            check_word(debug_wb_pc_o, w.pc, "write-back pc");
            check_reg(debug_wb_rf_wnum_o, w.dest, "write-back register");
            check_word(debug_wb_rf_wdata_o, w.data, "write-back data");
        end else begin
            check_wen(debug_wb_rf_wen_o, '0, $sformatf("write enable for pc %h", hist_pc[3]));
        end
        if (hist_vld[3] && hist_pc[3] == LAST_PC)
            trace_done = 1'b1;
    endtask

    task automatic step_cycle();
        word_t offset;
        // Data for the address seen one cycle earlier
        inst_sram_rdata_i = fetch_word;
        if (inst_sram_en_o === 1'b1) begin
            check_word(inst_sram_addr_o, next_pc, "fetch address");
            offset        = inst_sram_addr_o - `MIPS_RESET_PC;
            fetch_word    = rom[offset[9:2]];
            next_pc       = next_pc + 32'd4;
            fetch_started = 1'b1;
        end else begin
            if (fetch_started)
                abort_run("instruction fetch enable dropped after the first fetch");
            fetch_word = '0;
        end
        for (int k = 3; k > 0; k--) begin
            hist_vld[k] = hist_vld[k-1];
            hist_pc[k]  = hist_pc[k-1];
        end
        hist_vld[0] = inst_sram_en_o;
        hist_pc[0]  = inst_sram_addr_o;
        check_trace();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        seed              = 32'hefe8_022e;
        clk               = 1'b0;
        reset_i           = 1'b1;
        inst_sram_rdata_i = '0;
        next_pc           = `MIPS_RESET_PC;
        fetch_word        = '0;
        fetch_started     = 1'b0;
        trace_done        = 1'b0;
        for (int k = 0; k < 4; k++) begin
            hist_vld[k] = 1'b0;
            hist_pc[k]  = '0;
        end
        for (int i = 0; i < ROM_WORDS; i++)
            rom[i] = gen_instr();
        run_model();

        // Three rising edges in reset
        for (int c = 0; c < 3; c++) begin
            @(negedge clk);
            check_wen(debug_wb_rf_wen_o, '0, "write enable during reset");
            if (inst_sram_en_o !== 1'b0)
                abort_run("instruction fetch enable is not low during reset");
        end
        reset_i = 1'b0;

        cycles = 0;
        while (!fetch_started && cycles < 4) begin
            @(negedge clk);
            step_cycle();
            cycles++;
        end
        if (!fetch_started)
            abort_run("timeout waiting for the first instruction fetch");

        cycles = 0;
        while (!trace_done && cycles < NUM_INSTR + 8) begin
            @(negedge clk);
            step_cycle();
            cycles++;
        end

        if (trace_done) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            abort_run("timeout waiting for the last instruction to reach the trace");
        end
    end

endmodule

/* verilog/mips_top.sv */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mips_top import mips_pkg::*; (
    input  logic                   clk,
    input  logic                   reset_i,
    output logic                   inst_sram_en_o,
    output word_t                  inst_sram_addr_o,
    input  word_t                  inst_sram_rdata_i,
    output word_t                  debug_wb_pc_o,
    output logic [`MIPS_WEN_W-1:0] debug_wb_rf_wen_o,
    output reg_addr_t              debug_wb_rf_wnum_o,
    output word_t                  debug_wb_rf_wdata_o
);

    wb_req_t ex_fwd;

    stage_link_if #(.payload_t(ex_req_t)) ex_link ();
    stage_link_if #(.payload_t(wb_req_t)) wb_link ();
    rf_read_if rf_rd ();

    mips_decode i_mips_decode (
        .clk               (clk),
        .reset_i           (reset_i),
        .inst_sram_en_o    (inst_sram_en_o),
        .inst_sram_addr_o  (inst_sram_addr_o),
        .inst_sram_rdata_i (inst_sram_rdata_i),
        .ex_link           (ex_link.source),
        .wb_link           (wb_link.monitor),
        .ex_fwd_i          (ex_fwd),
        .rf_rd             (rf_rd.requester)
    );

    mips_execute i_mips_execute (
        .clk      (clk),
        .reset_i  (reset_i),
        .ex_link  (ex_link.sink),
        .wb_link  (wb_link.source),
        .ex_fwd_o (ex_fwd)
    );

    mips_result i_mips_result (
        .clk                 (clk),
        .reset_i             (reset_i),
        .wb_link             (wb_link.sink),
        .rf_rd               (rf_rd.provider),
        .debug_wb_pc_o       (debug_wb_pc_o),
        .debug_wb_rf_wen_o   (debug_wb_rf_wen_o),
        .debug_wb_rf_wnum_o  (debug_wb_rf_wnum_o),
        .debug_wb_rf_wdata_o (debug_wb_rf_wdata_o)
    );

endmodule

/* verilog/mips_result.sv */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mips_result import mips_pkg::*; (
    input  logic                   clk,
    input  logic                   reset_i,
    stage_link_if.sink             wb_link,
    rf_read_if.provider            rf_rd,
    output word_t                  debug_wb_pc_o,
    output logic [`MIPS_WEN_W-1:0] debug_wb_rf_wen_o,
    output reg_addr_t              debug_wb_rf_wnum_o,
    output word_t                  debug_wb_rf_wdata_o
);

    localparam int RF_DEPTH = 2 ** `MIPS_REG_AW;

    // No storage behind $0
    word_t   regs [1:RF_DEPTH-1];
    wb_req_t wb;
    logic    wr_en;

    assign wb    = wb_link.payload;
    assign wr_en = wb_link.valid && wb.wen && (wb.dest != '0);

    //////////////////////////////////////////////////////////////////////
    // Register file
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 1; i < RF_DEPTH; i++)
                regs[i] <= '0;
        end else if (wr_en) begin
            regs[wb.dest] <= wb.data;
        end
    end

    // Combinational reads
    // A write in this cycle reaches decode through forwarding
    assign rf_rd.rdata_a = (rf_rd.raddr_a == '0) ? '0 : regs[rf_rd.raddr_a];
    assign rf_rd.rdata_b = (rf_rd.raddr_b == '0) ? '0 : regs[rf_rd.raddr_b];

    //////////////////////////////////////////////////////////////////////
    // Debug trace
    //////////////////////////////////////////////////////////////////////

    assign debug_wb_pc_o       = wb.pc;
    assign debug_wb_rf_wen_o   = {`MIPS_WEN_W{wr_en}};
    assign debug_wb_rf_wnum_o  = wb.dest;
    assign debug_wb_rf_wdata_o = wb.data;

    // Decode never lets a $0 write reach this stage
    no_zero_write_a: assert property (@(posedge clk) disable iff (reset_i)
        wb_link.valid && wb.wen |-> wb.dest != '0);

endmodule

/* verilog/mips_execute.sv */
`timescale 1ns/1ps

module mips_execute import mips_pkg::*; (
    input  logic         clk,
    input  logic         reset_i,
    stage_link_if.sink   ex_link,
    stage_link_if.source wb_link,
    output wb_req_t      ex_fwd_o
);

    ex_req_t req;
    word_t   alu_y;

    assign req = ex_link.payload;

    //////////////////////////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (req.op)
            ALU_ADDU,
            ALU_ADDIU: alu_y = req.a + req.b;
            ALU_SUBU:  alu_y = req.a - req.b;
            ALU_AND,
            ALU_ANDI:  alu_y = req.a & req.b;
            ALU_OR,
            ALU_ORI:   alu_y = req.a | req.b;
            ALU_XOR,
            ALU_XORI:  alu_y = req.a ^ req.b;
            ALU_NOR:   alu_y = ~(req.a | req.b);
            ALU_SLT:   alu_y = word_t'($signed(req.a) < $signed(req.b));
            ALU_SLTU:  alu_y = word_t'(req.a < req.b);
            // Shift amount sits in operand a
            ALU_SLL:   alu_y = req.b << req.a[4:0];
            ALU_SRL:   alu_y = req.b >> req.a[4:0];
            ALU_SRA:   alu_y = word_t'($signed(req.b) >>> req.a[4:0]);
            // Already shifted in decode
            ALU_LUI:   alu_y = req.b;
            default:   alu_y = '0;
        endcase
    end

    // Same-cycle bypass to decode, valid folded into the write flag
    always_comb begin
        ex_fwd_o.pc   = req.pc;
        ex_fwd_o.dest = req.dest;
        ex_fwd_o.wen  = ex_link.valid && req.wen;
        ex_fwd_o.data = alu_y;
    end

    //////////////////////////////////////////////////////////////////////
    // Pipeline register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_i)
            wb_link.valid <= 1'b0;
        else
            wb_link.valid <= ex_link.valid;
    end

    always_ff @(posedge clk) begin
        wb_link.payload <= ex_fwd_o;
    end

    valid_known_a: assert property (@(posedge clk) disable iff (reset_i)
        !$isunknown(ex_link.valid) && !$isunknown(wb_link.valid));

endmodule

/* verilog/mips_decode.sv */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mips_decode import mips_pkg::*; (
    input  logic          clk,
    input  logic          reset_i,
    output logic          inst_sram_en_o,
    output word_t         inst_sram_addr_o,
    input  word_t         inst_sram_rdata_i,
    stage_link_if.source  ex_link,
    stage_link_if.monitor wb_link,
    input  wb_req_t       ex_fwd_i,
    rf_read_if.requester  rf_rd
);

    logic      en_q;
    logic      fetch_valid_q;
    word_t     pc_q;
    word_t     fetch_pc_q;
    word_t     inst;
    logic [5:0] opcode;
    logic [5:0] funct;
    logic [4:0] shamt;
    logic [15:0] imm;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    reg_addr_t dest;
    alu_op_t   alu_op;
    logic      a_shamt;
    logic      b_imm;
    word_t     imm_val;
    word_t     rs_val;
    word_t     rt_val;
    ex_req_t   ex_req_d;

    // Newest producer wins, $0 is hard zero
    function automatic word_t resolve(input reg_addr_t src, input word_t rf_val,
                                      input wb_req_t ex_fwd, input logic wb_vld,
                                      input wb_req_t wb_req);
        if (src == '0)
            return '0;
        else if (ex_fwd.wen && ex_fwd.dest == src)
            return ex_fwd.data;
        else if (wb_vld && wb_req.wen && wb_req.dest == src)
            return wb_req.data;
        else
            return rf_val;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // PC and fetch
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_i) begin
            en_q          <= 1'b0;
            pc_q          <= `MIPS_RESET_PC;
            fetch_valid_q <= 1'b0;
            ex_link.valid <= 1'b0;
        end else begin
            en_q <= 1'b1;
            if (en_q)
                pc_q <= pc_q + 32'd4;
            // Memory answers one cycle after the address
            fetch_valid_q <= en_q;
            ex_link.valid <= fetch_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        fetch_pc_q      <= pc_q;
        ex_link.payload <= ex_req_d;
    end

    assign inst_sram_en_o   = en_q;
    assign inst_sram_addr_o = pc_q;

    //////////////////////////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////////////////////////

    assign inst   = inst_sram_rdata_i;
    assign opcode = inst[31:26];
    assign rs     = inst[25:21];
    assign rt     = inst[20:16];
    assign rd     = inst[15:11];
    assign shamt  = inst[10:6];
    assign funct  = inst[5:0];
    assign imm    = inst[15:0];

    always_comb begin
        alu_op  = ALU_NOP;
        a_shamt = 1'b0;
        b_imm   = 1'b0;
        dest    = rd;
        imm_val = word_t'(imm);
        case (opcode)
            `MIPS_OP_SPECIAL: begin
                case (funct)
                    `MIPS_FN_ADDU: alu_op = ALU_ADDU;
                    `MIPS_FN_SUBU: alu_op = ALU_SUBU;
                    `MIPS_FN_AND:  alu_op = ALU_AND;
                    `MIPS_FN_OR:   alu_op = ALU_OR;
                    `MIPS_FN_XOR:  alu_op = ALU_XOR;
                    `MIPS_FN_NOR:  alu_op = ALU_NOR;
                    `MIPS_FN_SLT:  alu_op = ALU_SLT;
                    `MIPS_FN_SLTU: alu_op = ALU_SLTU;
                    `MIPS_FN_SLL: begin
                        alu_op  = ALU_SLL;
                        a_shamt = 1'b1;
                    end
                    `MIPS_FN_SRL: begin
                        alu_op  = ALU_SRL;
                        a_shamt = 1'b1;
                    end
                    `MIPS_FN_SRA: begin
                        alu_op  = ALU_SRA;
                        a_shamt = 1'b1;
                    end
                    default: alu_op = ALU_NOP;
                endcase
            end
            `MIPS_OP_ADDIU: begin
                alu_op  = ALU_ADDIU;
                imm_val = {{16{imm[15]}}, imm};
            end
            `MIPS_OP_ANDI: alu_op = ALU_ANDI;
            `MIPS_OP_ORI:  alu_op = ALU_ORI;
            `MIPS_OP_XORI: alu_op = ALU_XORI;
            `MIPS_OP_LUI: begin
                alu_op  = ALU_LUI;
                imm_val = {imm, 16'h0000};
            end
            default: alu_op = ALU_NOP;
        endcase
        // I-type writes rt
        if (opcode != `MIPS_OP_SPECIAL) begin
            b_imm = 1'b1;
            dest  = rt;
        end
    end

    assign rf_rd.raddr_a = rs;
    assign rf_rd.raddr_b = rt;
    assign rs_val = resolve(rs, rf_rd.rdata_a, ex_fwd_i, wb_link.valid, wb_link.payload);
    assign rt_val = resolve(rt, rf_rd.rdata_b, ex_fwd_i, wb_link.valid, wb_link.payload);

    always_comb begin
        ex_req_d.op   = alu_op;
        ex_req_d.a    = a_shamt ? word_t'(shamt) : rs_val;
        ex_req_d.b    = b_imm ? imm_val : rt_val;
        ex_req_d.dest = dest;
        // Writes to $0 are dropped here
        ex_req_d.wen  = (alu_op != ALU_NOP) && (dest != '0);
        ex_req_d.pc   = fetch_pc_q;
    end

    pc_aligned_a: assert property (@(posedge clk) disable iff (reset_i)
        en_q |-> pc_q[1:0] == 2'b00);

endmodule

/* verilog/mips_if.sv */
`timescale 1ns/1ps

//////////////////////////////////////////////////////////////////////
// Stage link, valid strobe plus payload, no back-pressure
//////////////////////////////////////////////////////////////////////

interface stage_link_if #(
    parameter type payload_t = logic
) ();

    logic     valid;
    payload_t payload;

    modport source (
        output valid,
        output payload
    );

    modport sink (
        input valid,
        input payload
    );

    // Forwarding taps
    modport monitor (
        input valid,
        input payload
    );

endinterface

//////////////////////////////////////////////////////////////////////
// Register file read ports
//////////////////////////////////////////////////////////////////////

interface rf_read_if import mips_pkg::*; ();

    reg_addr_t raddr_a;
    reg_addr_t raddr_b;
    word_t     rdata_a;
    word_t     rdata_b;

    modport requester (
        output raddr_a,
        output raddr_b,
        input  rdata_a,
        input  rdata_b
    );

    modport provider (
        input  raddr_a,
        input  raddr_b,
        output rdata_a,
        output rdata_b
    );

endinterface

/* verilog/mips_pkg.sv */
package mips_pkg;

`include "mips_cfg.svh"

    typedef logic [`MIPS_WORD_W-1:0] word_t;
    typedef logic [`MIPS_REG_AW-1:0] reg_addr_t;

    // Immediate forms keep their own codes so the trace of a payload stays readable
    typedef enum logic [4:0] {
        ALU_NOP,
        ALU_ADDU,
        ALU_SUBU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_ADDIU,
        ALU_ANDI,
        ALU_ORI,
        ALU_XORI,
        ALU_LUI
    } alu_op_t;

    typedef struct packed {
        alu_op_t   op;
        word_t     a;
        word_t     b;
        reg_addr_t dest;
        logic      wen;
        word_t     pc;
    } ex_req_t;

    typedef struct packed {
        word_t     pc;
        reg_addr_t dest;
        logic      wen;
        word_t     data;
    } wb_req_t;

endpackage

/* verilog/mips_cfg.svh */
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

`define MIPS_WORD_W   32
`define MIPS_REG_AW   5
`define MIPS_RESET_PC 32'hbfc0_0000
`define MIPS_WEN_W    4

// Primary opcodes
`define MIPS_OP_SPECIAL 6'h00
`define MIPS_OP_ADDIU   6'h09
`define MIPS_OP_ANDI    6'h0c
`define MIPS_OP_ORI     6'h0d
`define MIPS_OP_XORI    6'h0e
`define MIPS_OP_LUI     6'h0f

// SPECIAL funct codes
`define MIPS_FN_SLL  6'h00
`define MIPS_FN_SRL  6'h02
`define MIPS_FN_SRA  6'h03
`define MIPS_FN_ADDU 6'h21
`define MIPS_FN_SUBU 6'h23
`define MIPS_FN_AND  6'h24
`define MIPS_FN_OR   6'h25
`define MIPS_FN_XOR  6'h26
`define MIPS_FN_NOR  6'h27
`define MIPS_FN_SLT  6'h2a
`define MIPS_FN_SLTU 6'h2b

`endif
